// File: include/mem_ss_defines.svh
/* Memory subsystem CSR defines */

`ifndef MEM_SS_DEFINES_SVH
`define MEM_SS_DEFINES_SVH

// ------------------------------
// Subsystem size
// ------------------------------

// DDR channels behind the subsystem
`define MEM_SS_DDR_CHANNEL 4

// Byte address of the 2 KB CSR window
`define MEM_SS_ADDR_WIDTH 11

// Bus and register width
`define MEM_SS_DATA_WIDTH 64

// ------------------------------
// Device feature header fields
// ------------------------------
`define MEM_SS_FEAT_ID   12'h9
`define MEM_SS_FEAT_VER  4'h1
`define MEM_SS_NEXT_DFH  24'h1000
// Not the last feature in the list
`define MEM_SS_EOL       1'b0

`endif

// File: verilog/mem_ss_pkg.sv
/* Memory subsystem types */

`include "mem_ss_defines.svh"

package mem_ss_pkg;

   // ------------------------------
   // Register map
   // ------------------------------

   // Byte offset of each register is index * 8
   typedef enum int unsigned {
      EMIF_DFH,          // 0x00
      EMIF_STATUS,       // 0x08
      EMIF_CAPABILITY,   // 0x10
      EMIF_SCRATCH,      // 0x18
      EMIF_NUM_REG
   } csr_idx_e;

   // One flag per DDR channel
   typedef logic [`MEM_SS_DDR_CHANNEL-1:0] chan_vec_t;

   // 64-bit word index out of a byte address
   function automatic logic [`MEM_SS_ADDR_WIDTH-4:0] csr_word_idx (
      input logic [`MEM_SS_ADDR_WIDTH-1:0] addr
   );
      return addr[`MEM_SS_ADDR_WIDTH-1:3];
   endfunction

endpackage

// File: verilog/csr_pkg.sv
/* Generic CSR types and update rule */

`include "mem_ss_defines.svh"

package csr_pkg;

   // ------------------------------
   // Types
   // ------------------------------

   // Per-bit access attribute
   typedef enum logic {
      RO = 1'b0,
      RW = 1'b1
   } csr_bit_attr_t;

   typedef logic [`MEM_SS_DATA_WIDTH-1:0]   csr_data_t;
   typedef logic [`MEM_SS_DATA_WIDTH/8-1:0] csr_strb_t;
   typedef csr_bit_attr_t [`MEM_SS_DATA_WIDTH-1:0] csr_attr_vec_t;

   // ------------------------------
   // Functions
   // ------------------------------

   // Same attribute on every bit of a register
   function automatic csr_attr_vec_t csr_attr_fill (input csr_bit_attr_t attr);
      csr_attr_vec_t vec;
      for (int b = 0; b < `MEM_SS_DATA_WIDTH; b++) begin
         vec[b] = attr;
      end
      return vec;
   endfunction

   // Next value of one register, bit by bit
   function automatic csr_data_t update_reg (
      input csr_attr_vec_t attr,
      input csr_data_t     reset_val,
      input csr_data_t     hw_val,
      input csr_data_t     cur_val,
      input logic          write_hit,
      input csr_data_t     wr_data,
      input csr_strb_t     wr_strb,
      input logic          reset_n
   );
      csr_data_t next_val;
      next_val = cur_val;
      for (int b = 0; b < `MEM_SS_DATA_WIDTH; b++) begin
         if (!reset_n) begin
            next_val[b] = reset_val[b];
         end else if (attr[b] == RO) begin
            // Hardware owns read-only bits
            next_val[b] = hw_val[b];
         end else if (write_hit && wr_strb[b/8]) begin
            next_val[b] = wr_data[b];
         end
      end
      return next_val;
   endfunction

endpackage

// File: verilog/axi_lite_csr_bridge.sv
/* AXI4-lite to CSR bridge */

`timescale 1ns/1ns
`include "mem_ss_defines.svh"

module axi_lite_csr_bridge (
   input  logic                            clk,
   input  logic                            rst_n,
   // Write address
   input  logic                            awvalid,
   output logic                            awready,
   input  logic [`MEM_SS_ADDR_WIDTH-1:0]   awaddr,
   // Write data
   input  logic                            wvalid,
   output logic                            wready,
   input  logic [`MEM_SS_DATA_WIDTH-1:0]   wdata,
   input  logic [`MEM_SS_DATA_WIDTH/8-1:0] wstrb,
   // Write response
   output logic                            bvalid,
   input  logic                            bready,
   output logic [1:0]                      bresp,
   // Read address
   input  logic                            arvalid,
   output logic                            arready,
   input  logic [`MEM_SS_ADDR_WIDTH-1:0]   araddr,
   // Read data
   output logic                            rvalid,
   input  logic                            rready,
   output logic [`MEM_SS_DATA_WIDTH-1:0]   rdata,
   output logic [1:0]                      rresp,
   // CSR side
   output logic                            csr_write,
   output logic [`MEM_SS_ADDR_WIDTH-1:0]   csr_waddr,
   output logic [`MEM_SS_DATA_WIDTH-1:0]   csr_wdata,
   output logic [`MEM_SS_DATA_WIDTH/8-1:0] csr_wstrb,
   output logic                            csr_read,
   output logic [`MEM_SS_ADDR_WIDTH-1:0]   csr_raddr,
   input  logic [`MEM_SS_DATA_WIDTH-1:0]   csr_readdata,
   input  logic                            csr_readdata_valid
);

   localparam logic [1:0] RESP_OKAY = 2'b00;

   typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_EXEC, WR_RESP} wr_state_e;
   typedef enum logic [2:0] {RD_IDLE, RD_ACCEPT, RD_ISSUE, RD_WAIT, RD_RESP} rd_state_e;

   wr_state_e wr_state;
   rd_state_e rd_state;

   // ------------------------------
   // Write FSM
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_state <= WR_IDLE;
      end else begin
         case (wr_state)
            // Address and data must both be present
            WR_IDLE:   if (awvalid && wvalid) wr_state <= WR_ACCEPT;
            WR_ACCEPT: wr_state <= (awvalid && wvalid) ? WR_EXEC : WR_IDLE;
            WR_EXEC:   wr_state <= WR_RESP;
            // Hold response until the host takes it
            WR_RESP:   if (bready) wr_state <= WR_IDLE;
            default:   wr_state <= WR_IDLE;
         endcase
      end
   end

   // Capture on the handshake edge
   always_ff @(posedge clk) begin
      if (wr_state == WR_ACCEPT && awvalid && wvalid) begin
         csr_waddr <= awaddr;
         csr_wdata <= wdata;
         csr_wstrb <= wstrb;
      end
   end

   assign awready   = (wr_state == WR_ACCEPT);
   assign wready    = (wr_state == WR_ACCEPT);
   assign csr_write = (wr_state == WR_EXEC);
   assign bvalid    = (wr_state == WR_RESP);
   assign bresp     = RESP_OKAY;

   // ------------------------------
   // Read FSM
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_state <= RD_IDLE;
      end else begin
         case (rd_state)
            RD_IDLE:   if (arvalid) rd_state <= RD_ACCEPT;
            RD_ACCEPT: rd_state <= arvalid ? RD_ISSUE : RD_IDLE;
            RD_ISSUE:  rd_state <= RD_WAIT;
            // Register file answers two cycles after the strobe
            RD_WAIT:   if (csr_readdata_valid) rd_state <= RD_RESP;
            RD_RESP:   if (rready) rd_state <= RD_IDLE;
            default:   rd_state <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_state == RD_ACCEPT && arvalid) begin
         csr_raddr <= araddr;
      end
      // Read data stays put until rready
      if (rd_state == RD_WAIT && csr_readdata_valid) begin
         rdata <= csr_readdata;
      end
   end

   assign arready  = (rd_state == RD_ACCEPT);
   assign csr_read = (rd_state == RD_ISSUE);
   assign rvalid   = (rd_state == RD_RESP);
   assign rresp    = RESP_OKAY;

   // ------------------------------
   // Assertions
   // ------------------------------

   // Register file only answers a read we issued
   ap_rdv_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      csr_readdata_valid |-> (rd_state == RD_WAIT))
      else $error("csr_readdata_valid without an outstanding read");

   ap_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (bvalid && !bready) |=> bvalid)
      else $error("bvalid dropped before bready");

endmodule

// File: verilog/emif_cal_monitor.sv
/* Calibration flag synchronizer */

`timescale 1ns/1ns

module emif_cal_monitor
   import mem_ss_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   // From the memory controller clock domain
   input  chan_vec_t cal_success,
   input  chan_vec_t cal_fail,
   // Local clock domain
   output chan_vec_t cal_success_sync,
   output chan_vec_t cal_fail_sync
);

   // First stage, may go metastable
   chan_vec_t success_meta;
   chan_vec_t fail_meta;

   // ------------------------------
   // Two-flop synchronizer
   // ------------------------------

   // Each bit is an independent level
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         success_meta     <= '0;
         fail_meta        <= '0;
         cal_success_sync <= '0;
         cal_fail_sync    <= '0;
      end else begin
         success_meta     <= cal_success;
         fail_meta        <= cal_fail;
         // Second stage settles the value
         cal_success_sync <= success_meta;
         cal_fail_sync    <= fail_meta;
      end
   end

   // ------------------------------
   // Consistency check
   // ------------------------------

   // Controller never reports pass and fail on one channel
   ap_cal_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      (cal_success_sync & cal_fail_sync) == '0)
      else $error("channel reports calibration success and fail together");

endmodule

// File: verilog/mem_ss_csr.sv
/* Memory subsystem register file */

`timescale 1ns/1ns
`include "mem_ss_defines.svh"

module mem_ss_csr
   import mem_ss_pkg::*;
   import csr_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst_n,
   // Write strobe
   input  logic                            csr_write,
   input  logic [`MEM_SS_ADDR_WIDTH-1:0]   csr_waddr,
   input  logic [`MEM_SS_DATA_WIDTH-1:0]   csr_wdata,
   input  logic [`MEM_SS_DATA_WIDTH/8-1:0] csr_wstrb,
   // Read strobe and response
   input  logic                            csr_read,
   input  logic [`MEM_SS_ADDR_WIDTH-1:0]   csr_raddr,
   output logic [`MEM_SS_DATA_WIDTH-1:0]   csr_readdata,
   output logic                            csr_readdata_valid,
   // Synchronized calibration flags
   input  chan_vec_t                       cal_success_sync,
   input  chan_vec_t                       cal_fail_sync
);

   localparam int DATA_W  = `MEM_SS_DATA_WIDTH;
   localparam int NUM_CH  = `MEM_SS_DDR_CHANNEL;
   localparam int NUM_REG = EMIF_NUM_REG;
   localparam int IDX_W   = `MEM_SS_ADDR_WIDTH - 3;
   // Bits needed to select an implemented register
   localparam int SEL_W   = $clog2(NUM_REG);

   localparam csr_attr_vec_t ATTR_RO = csr_attr_fill(RO);
   localparam csr_attr_vec_t ATTR_RW = csr_attr_fill(RW);

   /*
      DFH layout
      [63:60] feature type, [59:41] reserved, [40] end of list,
      [39:16] next DFH offset, [15:12] version, [11:0] feature id
   */
   localparam csr_data_t DFH_VAL = {4'h3, 8'h0, 4'h0, 7'h0, `MEM_SS_EOL,
                                    `MEM_SS_NEXT_DFH, `MEM_SS_FEAT_VER, `MEM_SS_FEAT_ID};

   // One bit per present channel
   localparam csr_data_t CAP_VAL = {{(DATA_W-NUM_CH){1'b0}}, {NUM_CH{1'b1}}};

   csr_data_t     csr_reg   [NUM_REG];
   csr_attr_vec_t reg_attr  [NUM_REG];
   csr_data_t     reg_rst   [NUM_REG];
   csr_data_t     reg_hw    [NUM_REG];

   logic             csr_read_reg;
   logic [SEL_W-1:0] rd_sel;
   logic             range_valid;
   logic [IDX_W-1:0] wr_idx;

   // ------------------------------
   // Register definitions
   // ------------------------------
   always_comb begin
      reg_attr[EMIF_DFH]        = ATTR_RO;
      reg_rst[EMIF_DFH]         = DFH_VAL;
      reg_hw[EMIF_DFH]          = DFH_VAL;

      // Fail flags sit above the success flags
      reg_attr[EMIF_STATUS]     = ATTR_RO;
      reg_rst[EMIF_STATUS]      = '0;
      reg_hw[EMIF_STATUS]       = {{(DATA_W-2*NUM_CH){1'b0}}, cal_fail_sync,
                                   cal_success_sync};

      reg_attr[EMIF_CAPABILITY] = ATTR_RO;
      reg_rst[EMIF_CAPABILITY]  = CAP_VAL;
      reg_hw[EMIF_CAPABILITY]   = CAP_VAL;

      // Scratchpad is software owned
      reg_attr[EMIF_SCRATCH]    = ATTR_RW;
      reg_rst[EMIF_SCRATCH]     = '0;
      reg_hw[EMIF_SCRATCH]      = '0;
   end

   // ------------------------------
   // Register update
   // ------------------------------
   assign wr_idx = csr_word_idx(csr_waddr);

   // Out of range writes match no index
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_REG; i++) begin
         csr_reg[i] <= update_reg(reg_attr[i], reg_rst[i], reg_hw[i], csr_reg[i],
                                  csr_write && (wr_idx == IDX_W'(i)),
                                  csr_wdata, csr_wstrb, rst_n);
      end
   end

   // ------------------------------
   // Read path
   // ------------------------------

   // Stage 1 registers the strobe and the range check
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_read_reg <= 1'b0;
      end else begin
         csr_read_reg <= csr_read;
      end
   end

   always_ff @(posedge clk) begin
      rd_sel      <= csr_raddr[SEL_W+2:3];
      range_valid <= (csr_word_idx(csr_raddr) < IDX_W'(NUM_REG));
   end

   // Stage 2 muxes the data, unmapped reads return zero
   always_ff @(posedge clk) begin
      csr_readdata <= '0;
      if (csr_read_reg && range_valid) begin
         csr_readdata <= csr_reg[rd_sel];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_readdata_valid <= 1'b0;
      end else begin
         csr_readdata_valid <= csr_read_reg;
      end
   end

   // ------------------------------
   // Assertions
   // ------------------------------

   // Bridge runs reads and writes apart on one register
   ap_no_rw_collision: assert property (@(posedge clk) disable iff (!rst_n)
      !(csr_read && csr_write && (csr_word_idx(csr_raddr) == wr_idx)))
      else $error("CSR read and write hit the same address in one cycle");

endmodule

// File: verilog/mem_ss_csr_top.sv
/* Memory subsystem CSR top */

`timescale 1ns/1ns
`include "mem_ss_defines.svh"

module mem_ss_csr_top
   import mem_ss_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst_n,
   // AXI4-lite slave
   input  logic                            awvalid,
   output logic                            awready,
   input  logic [`MEM_SS_ADDR_WIDTH-1:0]   awaddr,
   input  logic                            wvalid,
   output logic                            wready,
   input  logic [`MEM_SS_DATA_WIDTH-1:0]   wdata,
   input  logic [`MEM_SS_DATA_WIDTH/8-1:0] wstrb,
   output logic                            bvalid,
   input  logic                            bready,
   output logic [1:0]                      bresp,
   input  logic                            arvalid,
   output logic                            arready,
   input  logic [`MEM_SS_ADDR_WIDTH-1:0]   araddr,
   output logic                            rvalid,
   input  logic                            rready,
   output logic [`MEM_SS_DATA_WIDTH-1:0]   rdata,
   output logic [1:0]                      rresp,
   // Calibration flags, asynchronous
   input  chan_vec_t                       cal_success,
   input  chan_vec_t                       cal_fail
);

   // Bridge to register file
   logic                            csr_write;
   logic [`MEM_SS_ADDR_WIDTH-1:0]   csr_waddr;
   logic [`MEM_SS_DATA_WIDTH-1:0]   csr_wdata;
   logic [`MEM_SS_DATA_WIDTH/8-1:0] csr_wstrb;
   logic                            csr_read;
   logic [`MEM_SS_ADDR_WIDTH-1:0]   csr_raddr;
   logic [`MEM_SS_DATA_WIDTH-1:0]   csr_readdata;
   logic                            csr_readdata_valid;

   // Monitor to register file
   chan_vec_t cal_success_sync;
   chan_vec_t cal_fail_sync;

   axi_lite_csr_bridge bridge_i (
      .clk                (clk),
      .rst_n              (rst_n),
      .awvalid            (awvalid),
      .awready            (awready),
      .awaddr             (awaddr),
      .wvalid             (wvalid),
      .wready             (wready),
      .wdata              (wdata),
      .wstrb              (wstrb),
      .bvalid             (bvalid),
      .bready             (bready),
      .bresp              (bresp),
      .arvalid            (arvalid),
      .arready            (arready),
      .araddr             (araddr),
      .rvalid             (rvalid),
      .rready             (rready),
      .rdata              (rdata),
      .rresp              (rresp),
      .csr_write          (csr_write),
      .csr_waddr          (csr_waddr),
      .csr_wdata          (csr_wdata),
      .csr_wstrb          (csr_wstrb),
      .csr_read           (csr_read),
      .csr_raddr          (csr_raddr),
      .csr_readdata       (csr_readdata),
      .csr_readdata_valid (csr_readdata_valid)
   );

   emif_cal_monitor cal_mon_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .cal_success      (cal_success),
      .cal_fail         (cal_fail),
      .cal_success_sync (cal_success_sync),
      .cal_fail_sync    (cal_fail_sync)
   );

   mem_ss_csr csr_i (
      .clk                (clk),
      .rst_n              (rst_n),
      .csr_write          (csr_write),
      .csr_waddr          (csr_waddr),
      .csr_wdata          (csr_wdata),
      .csr_wstrb          (csr_wstrb),
      .csr_read           (csr_read),
      .csr_raddr          (csr_raddr),
      .csr_readdata       (csr_readdata),
      .csr_readdata_valid (csr_readdata_valid),
      .cal_success_sync   (cal_success_sync),
      .cal_fail_sync      (cal_fail_sync)
   );

endmodule

// File: bench/mem_ss_csr_tb.sv
/* Memory subsystem CSR testbench */

`timescale 1ns/1ns
`include "mem_ss_defines.svh"

module mem_ss_csr_tb
   import mem_ss_pkg::*;
();

   localparam int AW  = `MEM_SS_ADDR_WIDTH;
   localparam int DW  = `MEM_SS_DATA_WIDTH;
   localparam int SW  = DW / 8;
   localparam int NCH = `MEM_SS_DDR_CHANNEL;
   localparam int TIMEOUT_CYCLES = 50;
   localparam int MAX_RUN_CYCLES = 20000;

   logic          clk;
   logic          rst_n;
   logic          awvalid;
   logic          awready;
   logic [AW-1:0] awaddr;
   logic          wvalid;
   logic          wready;
   logic [DW-1:0] wdata;
   logic [SW-1:0] wstrb;
   logic          bvalid;
   logic          bready;
   logic [1:0]    bresp;
   logic          arvalid;
   logic          arready;
   logic [AW-1:0] araddr;
   logic          rvalid;
   logic          rready;
   logic [DW-1:0] rdata;
   logic [1:0]    rresp;
   chan_vec_t     cal_success;
   chan_vec_t     cal_fail;

   integer seed          = 32'h1e5a0d5e;
   int     error_count   = 0;
   int     check_count   = 0;
   logic   hang_detected = 1'b0;

   // Model state
   logic [DW-1:0] model_scratch;
   chan_vec_t     model_success;
   chan_vec_t     model_fail;

   // Expected read data, oldest first
   logic [DW-1:0] exp_rdata_q[$];
   logic [AW-1:0] exp_addr_q[$];
   logic [DW-1:0] exp_data;
   logic [AW-1:0] exp_addr;

   mem_ss_csr_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   // Back-pressure of 0 to 7 cycles
   function automatic int rand_hold();
      logic [31:0] r;
      r = rand32();
      return int'(r[2:0]);
   endfunction

   function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_val,
                                                 input logic [DW-1:0] data,
                                                 input logic [SW-1:0] strb);
      logic [DW-1:0] val;
      val = old_val;
      for (int b = 0; b < SW; b++) begin
         if (strb[b]) val[8*b +: 8] = data[8*b +: 8];
      end
      return val;
   endfunction

   // Expected register contents at a byte address
   function automatic logic [DW-1:0] exp_reg(input logic [AW-1:0] addr);
      logic [DW-1:0] val;
      int            idx;
      val = '0;
      idx = int'(addr[AW-1:3]);
      case (idx)
         EMIF_DFH: begin
            // Feature type 3, reserved bits stay zero
            val[63:60] = 4'h3;
            val[40]    = `MEM_SS_EOL;
            val[39:16] = `MEM_SS_NEXT_DFH;
            val[15:12] = `MEM_SS_FEAT_VER;
            val[11:0]  = `MEM_SS_FEAT_ID;
         end
         EMIF_STATUS: begin
            val[NCH-1:0]     = model_success;
            val[2*NCH-1:NCH] = model_fail;
         end
         EMIF_CAPABILITY: val[NCH-1:0] = '1;
         EMIF_SCRATCH:    val = model_scratch;
         default:         val = '0;
      endcase
      return val;
   endfunction

   task automatic report_timeout(input string what);
      $display("ERROR: timeout waiting for %s", what);
      error_count++;
      hang_detected = 1'b1;
   endtask

   // ------------------------------
   // AXI4-lite driver
   // ------------------------------
   task automatic axi_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                            input logic [SW-1:0] strb, input int hold);
      int   cnt;
      logic seen;
      if (int'(addr[AW-1:3]) == EMIF_SCRATCH) begin
         model_scratch = merge_bytes(model_scratch, data, strb);
      end
      @(posedge clk);
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      cnt  = 0;
      seen = 1'b0;
      while (!seen && cnt < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cnt++;
         seen = awready && wready;
      end
      if (!seen) begin
         report_timeout("awready and wready");
         return;
      end
      // Handshake edge
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      cnt  = 0;
      seen = 1'b0;
      while (!seen && cnt < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cnt++;
         seen = bvalid;
      end
      if (!seen) begin
         report_timeout("bvalid");
         return;
      end
      if (cnt != 2) begin
         $display("ERROR: bvalid came %0d cycles after acceptance instead of 2", cnt);
         error_count++;
      end
      repeat (hold) begin
         @(negedge clk);
         if (!bvalid) begin
            $display("ERROR: bvalid dropped while bready was low");
            error_count++;
         end
      end
      @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [AW-1:0] addr, input int hold);
      int            cnt;
      logic          seen;
      logic [DW-1:0] held;
      exp_rdata_q.push_back(exp_reg(addr));
      exp_addr_q.push_back(addr);
      @(posedge clk);
      arvalid <= 1'b1;
      araddr  <= addr;
      cnt  = 0;
      seen = 1'b0;
      while (!seen && cnt < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cnt++;
         seen = arready;
      end
      if (!seen) begin
         report_timeout("arready");
         return;
      end
      @(posedge clk);
      arvalid <= 1'b0;
      cnt  = 0;
      seen = 1'b0;
      while (!seen && cnt < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cnt++;
         seen = rvalid;
      end
      if (!seen) begin
         report_timeout("rvalid");
         return;
      end
      if (cnt != 4) begin
         $display("ERROR: rvalid came %0d cycles after arready instead of 4", cnt);
         error_count++;
      end
      // Data must not move while the host stalls
      held = rdata;
      repeat (hold) begin
         @(negedge clk);
         if (!rvalid) begin
            $display("ERROR: rvalid dropped while rready was low");
            error_count++;
         end
         if (rdata !== held) begin
            $display("MISMATCH rdata during stall: expected 0x%h, got 0x%h", held, rdata);
            error_count++;
         end
      end
      @(posedge clk);
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   // ------------------------------
   // Response checker
   // ------------------------------

   // Sampled at negedge, one cycle of rready or bready per response
   always @(negedge clk) begin
      if (rst_n && rvalid && rready) begin
         check_count++;
         if (exp_rdata_q.size() == 0) begin
            $display("ERROR: read data returned with no read outstanding");
            error_count++;
         end else begin
            exp_data = exp_rdata_q.pop_front();
            exp_addr = exp_addr_q.pop_front();
            if (rdata !== exp_data) begin
               $display("MISMATCH rdata at 0x%h: expected 0x%h, got 0x%h",
                        exp_addr, exp_data, rdata);
               error_count++;
            end
         end
         if (rresp !== 2'b00) begin
            $display("MISMATCH rresp: expected 0x0, got 0x%h", rresp);
            error_count++;
         end
      end
      if (rst_n && bvalid && bready) begin
         check_count++;
         if (bresp !== 2'b00) begin
            $display("MISMATCH bresp: expected 0x0, got 0x%h", bresp);
            error_count++;
         end
      end
   end

   // Ends the run after a timeout or a runaway sequence
   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (!hang_detected && cycles < MAX_RUN_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      if (!hang_detected) begin
         $display("ERROR: test sequence did not finish within %0d cycles", MAX_RUN_CYCLES);
         error_count++;
      end
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("STATUS: FAIL");
      $finish;
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      logic [DW-1:0] data;
      logic [SW-1:0] strb;
      logic [31:0]   rnd;
      chan_vec_t     succ;
      chan_vec_t     fail;
      awvalid     <= 1'b0;
      awaddr      <= '0;
      wvalid      <= 1'b0;
      wdata       <= '0;
      wstrb       <= '0;
      bready      <= 1'b0;
      arvalid     <= 1'b0;
      araddr      <= '0;
      rready      <= 1'b0;
      cal_success <= '0;
      cal_fail    <= '0;
      rst_n       <= 1'b0;
      model_scratch = '0;
      model_success = '0;
      model_fail    = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      if (awready || wready || arready || bvalid || rvalid) begin
         $display("ERROR: handshake outputs not low after reset");
         error_count++;
      end

      // Reset values
      axi_read(11'h000, 0);
      axi_read(11'h008, 0);
      axi_read(11'h010, 0);
      axi_read(11'h018, 0);

      // Scratchpad byte merging
      repeat (16) begin
         data = {rand32(), rand32()};
         rnd  = rand32();
         strb = rnd[SW-1:0];
         axi_write(11'h018, data, strb, 0);
         axi_read(11'h018, 0);
      end

      // Read-only registers ignore writes
      axi_write(11'h000, {rand32(), rand32()}, 8'hFF, 0);
      axi_read(11'h000, 0);
      axi_write(11'h008, {rand32(), rand32()}, 8'hFF, 0);
      axi_read(11'h008, 0);
      axi_write(11'h010, {rand32(), rand32()}, 8'hFF, 0);
      axi_read(11'h010, 0);

      // Calibration flags, never pass and fail on one channel
      repeat (10) begin
         rnd  = rand32();
         succ = rnd[NCH-1:0];
         fail = rnd[2*NCH-1:NCH] & ~succ;
         @(posedge clk);
         cal_success <= succ;
         cal_fail    <= fail;
         model_success = succ;
         model_fail    = fail;
         repeat (6) @(posedge clk);
         axi_read(11'h008, 0);
      end

      // Unmapped space reads zero and drops writes
      axi_read(11'h020, 0);
      axi_read(11'h7F8, 0);
      // Low index bits of 0x7F8 match the scratchpad
      axi_write(11'h7F8, {rand32(), rand32()}, 8'hFF, 0);
      axi_read(11'h018, 0);

      // Back-pressure on bready and rready
      repeat (12) begin
         data = {rand32(), rand32()};
         rnd  = rand32();
         strb = rnd[SW-1:0];
         axi_write(11'h018, data, strb, rand_hold());
         axi_read(11'h018, rand_hold());
         axi_read(11'h000, rand_hold());
      end

      repeat (4) @(posedge clk);
      if (exp_rdata_q.size() != 0) begin
         $display("ERROR: %0d read responses never arrived", exp_rdata_q.size());
         error_count++;
      end
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: mem_ss_csr_top.f
+incdir+include
verilog/mem_ss_pkg.sv
verilog/csr_pkg.sv
verilog/axi_lite_csr_bridge.sv
verilog/emif_cal_monitor.sv
verilog/mem_ss_csr.sv
verilog/mem_ss_csr_top.sv
bench/mem_ss_csr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem CSR testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module mem_ss_csr_tb \
   -f mem_ss_csr_top.f \
   -o mem_ss_csr_sim

# The log decides the result, not the exit code of the simulator
./obj_dir/mem_ss_csr_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
